//--- Makefile
SRCS := $(shell grep -v '^+' project.f)

obj_dir/Vforth_tb: project.f $(SRCS) test/forth_programs.svh
	verilator --binary --timing --assert -Wno-fatal --top-module forth_tb \
		-f project.f -Mdir obj_dir -o Vforth_tb

.PHONY: run clean

run: obj_dir/Vforth_tb
	@out=$$(./obj_dir/Vforth_tb); echo "$$out"; \
		echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

//--- design/data_stack.sv
// tos and s0 in registers, deeper cells in a small ram
// cells below the stack bottom read as zero

module data_stack (
    input  logic clk,
    input  logic rst,
    input  logic clr,
    ss_io.slave  ss
);

    localparam logic [forth_cfg_pkg::SPW-1:0] FULL =
        forth_cfg_pkg::SPW'(forth_cfg_pkg::SDEPTH + 2);

    logic [forth_cfg_pkg::DSZ-1:0] ram [forth_cfg_pkg::SDEPTH];
    logic [forth_cfg_pkg::SPW-1:0] wr_idx;
    logic [forth_cfg_pkg::SPW-1:0] rd_idx;
    logic [forth_cfg_pkg::DSZ-1:0] rd_val;
    logic                          spill;

    always_comb begin
        wr_idx = ss.depth - forth_cfg_pkg::SPW'(2);   // first free ram cell
        rd_idx = ss.depth - forth_cfg_pkg::SPW'(3);   // top ram cell
        spill  = (ss.op == forth_op_pkg::SS_PUSH) && !clr
                 && (ss.depth >= forth_cfg_pkg::SPW'(2));
        rd_val = (ss.depth >= forth_cfg_pkg::SPW'(3)) ? ram[rd_idx[forth_cfg_pkg::SAW-1:0]] : '0;
    end

    always_ff @(posedge clk) begin
        if (spill) begin
            ram[wr_idx[forth_cfg_pkg::SAW-1:0]] <= ss.s0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            ss.tos   <= '0;
            ss.s0    <= '0;
            ss.depth <= '0;
        end else begin
            case (ss.op)
                forth_op_pkg::SS_LOAD: begin
                    ss.tos <= ss.nxt_tos;
                    if (ss.swap) begin
                        ss.s0 <= ss.tos;
                    end
                end
                forth_op_pkg::SS_PUSH: begin
                    ss.tos   <= ss.nxt_tos;
                    ss.s0    <= ss.tos;
                    ss.depth <= ss.depth + 1'b1;
                end
                forth_op_pkg::SS_POP: begin
                    ss.tos   <= ss.nxt_tos;
                    ss.s0    <= rd_val;         // refill from ram
                    ss.depth <= ss.depth - 1'b1;
                end
                default: ss.depth <= ss.depth; // hold
            endcase
        end
    end

    a_no_push_full: assert property (
        @(posedge clk) disable iff (rst)
        (ss.op == forth_op_pkg::SS_PUSH && !clr) |-> (ss.depth != FULL)
    );

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst)
        (ss.op == forth_op_pkg::SS_POP && !clr) |-> (ss.depth != '0)
    );

endmodule

//--- design/exec_unit.sv
// executes the queue head in the cycle it shows up, one op per cycle
// done pulses the cycle after BYE, bsy drops at the same edge

module exec_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic                    empty,
    input  forth_op_pkg::op_entry_t head,
    output logic                    pop,
    ss_io.master                    ss,
    output logic                    bsy,
    output logic                    done
);

    logic is_bye;

    always_comb begin
        pop     = bsy && !empty && !start;   // start flushes the queue instead
        is_bye  = pop && (head.op == forth_op_pkg::OP_BYE);

        ss.op      = forth_op_pkg::SS_HOLD;
        ss.swap    = 1'b0;
        ss.nxt_tos = ss.tos;
        if (pop) begin
            case (head.op)
                forth_op_pkg::OP_DOLIT: begin
                    ss.op      = forth_op_pkg::SS_PUSH;
                    ss.nxt_tos = {{(forth_cfg_pkg::DSZ - 8){1'b0}}, head.lit};
                end
                forth_op_pkg::OP_DUP:  ss.op = forth_op_pkg::SS_PUSH;  // nxt_tos is tos
                forth_op_pkg::OP_OVER: begin
                    ss.op      = forth_op_pkg::SS_PUSH;
                    ss.nxt_tos = ss.s0;
                end
                forth_op_pkg::OP_DROP: begin
                    ss.op      = forth_op_pkg::SS_POP;
                    ss.nxt_tos = ss.s0;
                end
                forth_op_pkg::OP_SWAP: begin
                    ss.op      = forth_op_pkg::SS_LOAD;
                    ss.swap    = 1'b1;
                    ss.nxt_tos = ss.s0;
                end
                forth_op_pkg::OP_ADD: begin
                    ss.op      = forth_op_pkg::SS_POP;
                    ss.nxt_tos = ss.s0 + ss.tos;
                end
                forth_op_pkg::OP_SUB: begin
                    ss.op      = forth_op_pkg::SS_POP;
                    ss.nxt_tos = ss.s0 - ss.tos;
                end
                forth_op_pkg::OP_MUL: begin
                    ss.op      = forth_op_pkg::SS_POP;
                    ss.nxt_tos = ss.s0 * ss.tos;   // low half only
                end
                forth_op_pkg::OP_AND: begin
                    ss.op      = forth_op_pkg::SS_POP;
                    ss.nxt_tos = ss.s0 & ss.tos;
                end
                forth_op_pkg::OP_OR: begin
                    ss.op      = forth_op_pkg::SS_POP;
                    ss.nxt_tos = ss.s0 | ss.tos;
                end
                forth_op_pkg::OP_XOR: begin
                    ss.op      = forth_op_pkg::SS_POP;
                    ss.nxt_tos = ss.s0 ^ ss.tos;
                end
                forth_op_pkg::OP_NEG: begin
                    ss.op      = forth_op_pkg::SS_LOAD;
                    ss.nxt_tos = -ss.tos;
                end
                default: ss.op = forth_op_pkg::SS_HOLD;  // NOP and BYE
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bsy  <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= is_bye;
            if (start) begin
                bsy <= 1'b1;
            end else if (is_bye) begin
                bsy <= 1'b0;
            end
        end
    end

endmodule

//--- design/forth_cfg_pkg.sv
// sizes of the byte-coded forth core
// QDEPTH must be a power of two, queue pointers wrap on their own
package forth_cfg_pkg;

    localparam int DSZ    = 32;              // data path width
    localparam int ASZ    = 8;               // program address width, 256 bytes
    localparam int QDEPTH = 4;               // opcode queue entries
    localparam int SDEPTH = 16;              // stack ram cells below s0
    localparam int SPW    = 5;               // depth counter, counts SDEPTH + tos + s0

    // derived widths
    localparam int QPW = $clog2(QDEPTH);     // queue pointer
    localparam int QCW = $clog2(QDEPTH + 1); // queue fill count
    localparam int SAW = $clog2(SDEPTH);     // stack ram address

endpackage

//--- design/forth_core.sv
// forth inner interpreter top, load the program first, then pulse start with pfa
// tos, s0 and depth hold after done until the next start

module forth_core (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          load_we,
    input  logic [forth_cfg_pkg::ASZ-1:0] load_addr,
    input  logic [7:0]                    load_data,
    input  logic                          start,
    input  logic [forth_cfg_pkg::ASZ-1:0] pfa,
    output logic                          bsy,
    output logic                          done,
    output logic [forth_cfg_pkg::DSZ-1:0] tos,
    output logic [forth_cfg_pkg::DSZ-1:0] s0,
    output logic [forth_cfg_pkg::SPW-1:0] depth
);

    mem_rd_io mem_if ();
    ss_io     ss_if ();

    logic                    q_wr_en;
    forth_op_pkg::op_entry_t q_wr_entry;
    logic                    q_room;
    logic                    q_pop;
    logic                    q_empty;
    forth_op_pkg::op_entry_t q_head;

    prog_mem u_mem (
        .clk(clk), .rst(rst),
        .load_we(load_we), .load_addr(load_addr), .load_data(load_data),
        .mem(mem_if.slave)
    );

    opcode_fetch u_fetch (
        .clk(clk), .rst(rst), .start(start), .pfa(pfa),
        .mem(mem_if.master), .room(q_room),
        .wr_en(q_wr_en), .wr_entry(q_wr_entry)
    );

    op_queue u_queue (
        .clk(clk), .rst(rst), .clr(start),           // flushed on every start
        .wr_en(q_wr_en), .wr_entry(q_wr_entry), .room(q_room),
        .pop(q_pop), .empty(q_empty), .head(q_head)
    );

    data_stack u_stack (
        .clk(clk), .rst(rst), .clr(start),
        .ss(ss_if.slave)
    );

    exec_unit u_exec (
        .clk(clk), .rst(rst), .start(start),
        .empty(q_empty), .head(q_head), .pop(q_pop),
        .ss(ss_if.master), .bsy(bsy), .done(done)
    );

    assign tos   = ss_if.tos;
    assign s0    = ss_if.s0;
    assign depth = ss_if.depth;

endmodule

//--- design/forth_if.sv
// links inside the core
// mem_rd_io: rd_vld follows rd_en by exactly one cycle, one read in flight at most

interface mem_rd_io;
    logic                            rd_en;   // read strobe
    logic [forth_cfg_pkg::ASZ-1:0]   addr;
    logic [7:0]                      rd_data; // valid with rd_vld
    logic                            rd_vld;

    modport master (output rd_en, addr, input rd_data, rd_vld);
    modport slave  (input rd_en, addr, output rd_data, rd_vld);
endinterface

// stack port, swap only has a meaning together with SS_LOAD
interface ss_io;
    forth_op_pkg::sop_e              op;
    logic                            swap;    // old tos goes to s0
    logic [forth_cfg_pkg::DSZ-1:0]   nxt_tos;
    logic [forth_cfg_pkg::DSZ-1:0]   tos;
    logic [forth_cfg_pkg::DSZ-1:0]   s0;
    logic [forth_cfg_pkg::SPW-1:0]   depth;   // cells on the stack incl. tos and s0

    modport master (
        output op, swap, nxt_tos,
        input  tos, s0, depth
    );
    modport slave (
        input  op, swap, nxt_tos,
        output tos, s0, depth
    );
endinterface

//--- design/forth_op_pkg.sv
// opcode set and stack operation codes of the inner interpreter
// opcode bytes above OP_BYE are not in the enum, fetch turns them into OP_NOP
package forth_op_pkg;

    // byte opcodes, values fixed by order
    typedef enum logic [7:0] {
        OP_NOP   = 8'd0,
        OP_DOLIT = 8'd1,   // followed by one literal byte
        OP_DUP   = 8'd2,
        OP_DROP  = 8'd3,
        OP_OVER  = 8'd4,
        OP_SWAP  = 8'd5,
        OP_ADD   = 8'd6,
        OP_SUB   = 8'd7,
        OP_MUL   = 8'd8,
        OP_AND   = 8'd9,
        OP_OR    = 8'd10,
        OP_XOR   = 8'd11,
        OP_NEG   = 8'd12,
        OP_BYE   = 8'd13   // ends the program
    } opcode_e;

    // stack operation applied at the next edge
    typedef enum logic [1:0] {
        SS_HOLD = 2'd0,    // no change
        SS_LOAD = 2'd1,    // tos only
        SS_PUSH = 2'd2,    // tos -> s0 -> ram
        SS_POP  = 2'd3     // ram -> s0, new tos
    } sop_e;

    // decoded queue entry, literal is zero for all but DOLIT
    typedef struct packed {
        opcode_e    op;
        logic [7:0] lit;
    } op_entry_t;

endpackage

//--- design/op_queue.sv
// circular FIFO of decoded entries, head is read combinationally
// room needs two free slots so a read already in flight always has a place

module op_queue (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    clr,
    input  logic                    wr_en,
    input  forth_op_pkg::op_entry_t wr_entry,
    output logic                    room,
    input  logic                    pop,
    output logic                    empty,
    output forth_op_pkg::op_entry_t head
);

    forth_op_pkg::op_entry_t       ent [forth_cfg_pkg::QDEPTH];
    logic [forth_cfg_pkg::QPW-1:0] wp;
    logic [forth_cfg_pkg::QPW-1:0] rp;
    logic [forth_cfg_pkg::QCW-1:0] cnt;

    always_ff @(posedge clk) begin
        if (wr_en && !clr) begin
            ent[wp] <= wr_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            wp  <= '0;
            rp  <= '0;
            cnt <= '0;
        end else begin
            if (wr_en) begin
                wp <= wp + 1'b1;   // wraps at QDEPTH
            end
            if (pop) begin
                rp <= rp + 1'b1;
            end
            cnt <= cnt + forth_cfg_pkg::QCW'(wr_en) - forth_cfg_pkg::QCW'(pop);
        end
    end

    assign empty = (cnt == '0);
    assign room  = (cnt <= forth_cfg_pkg::QCW'(forth_cfg_pkg::QDEPTH - 2));
    assign head  = ent[rp];

    a_no_write_full: assert property (
        @(posedge clk) disable iff (rst)
        (wr_en && !clr) |-> (cnt != forth_cfg_pkg::QCW'(forth_cfg_pkg::QDEPTH))
    );

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst)
        (pop && !clr) |-> !empty
    );

endmodule

//--- design/opcode_fetch.sv
// walks ip from pfa, one read in flight, reads only while the queue has room
// one entry per byte, DOLIT and its literal byte become a single entry

module opcode_fetch (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  logic [forth_cfg_pkg::ASZ-1:0] pfa,
    mem_rd_io.master                      mem,
    input  logic                          room,
    output logic                          wr_en,
    output forth_op_pkg::op_entry_t       wr_entry
);

    typedef enum logic [1:0] {
        F_IDLE,
        F_OP,     // next byte is an opcode
        F_LIT,    // next byte is a DOLIT literal
        F_STOP    // BYE queued, wait for start
    } fstate_e;

    fstate_e                       state;
    logic [forth_cfg_pkg::ASZ-1:0] ip;
    logic                          running;
    forth_op_pkg::opcode_e         rd_op;

    always_comb begin
        running = (state == F_OP) || (state == F_LIT);
        // a returning byte blocks the next read, so rd_vld also marks the read in flight
        mem.rd_en = running && room && !mem.rd_vld && !start;
        mem.addr  = ip;

        // unknown bytes run as NOP
        if (mem.rd_data <= forth_op_pkg::OP_BYE) begin
            rd_op = forth_op_pkg::opcode_e'(mem.rd_data);
        end else begin
            rd_op = forth_op_pkg::OP_NOP;
        end

        wr_en          = 1'b0;
        wr_entry.op    = rd_op;
        wr_entry.lit   = 8'h00;
        if (mem.rd_vld && !start) begin
            case (state)
                F_OP: wr_en = (rd_op != forth_op_pkg::OP_DOLIT); // DOLIT waits for its byte
                F_LIT: begin
                    wr_en        = 1'b1;
                    wr_entry.op  = forth_op_pkg::OP_DOLIT;
                    wr_entry.lit = mem.rd_data;
                end
                default: wr_en = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= F_IDLE;
            ip    <= '0;
        end else if (start) begin
            state <= F_OP;
            ip    <= pfa;
        end else begin
            if (mem.rd_en) begin
                ip <= ip + 1'b1;
            end
            if (mem.rd_vld) begin
                case (state)
                    F_OP: begin
                        if (rd_op == forth_op_pkg::OP_DOLIT) begin
                            state <= F_LIT;
                        end else if (rd_op == forth_op_pkg::OP_BYE) begin
                            state <= F_STOP;
                        end
                    end
                    F_LIT:   state <= F_OP;
                    default: state <= state;
                endcase
            end
        end
    end

    // room seen at read time must still hold when the byte lands
    a_wr_with_room: assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> room
    );

endmodule

//--- design/prog_mem.sv
// byte program memory, host writes only while the core is not fetching
// read data is registered, no reset on the array

module prog_mem (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          load_we,
    input  logic [forth_cfg_pkg::ASZ-1:0] load_addr,
    input  logic [7:0]                    load_data,
    mem_rd_io.slave                       mem
);

    logic [7:0] ram [2**forth_cfg_pkg::ASZ];

    always_ff @(posedge clk) begin
        if (load_we) begin
            ram[load_addr] <= load_data;   // host load port
        end
        if (mem.rd_en) begin
            mem.rd_data <= ram[mem.addr];
        end
    end

    // valid strobe one cycle behind the read
    always_ff @(posedge clk) begin
        if (rst) begin
            mem.rd_vld <= 1'b0;
        end else begin
            mem.rd_vld <= mem.rd_en;
        end
    end

    // loading happens before start, never during a run
    a_no_load_during_read: assert property (
        @(posedge clk) disable iff (rst)
        !(load_we && mem.rd_en)
    );

endmodule

//--- project.f
+incdir+test
design/forth_cfg_pkg.sv
design/forth_op_pkg.sv
design/forth_if.sv
design/prog_mem.sv
design/opcode_fetch.sv
design/op_queue.sv
design/data_stack.sv
design/exec_unit.sv
design/forth_core.sv
test/forth_tb.sv

//--- test/forth_programs.svh
// program table for forth_tb, one row per run, bytes load upward from base
// rnd rows get lfsr literals in every DOLIT slot, their expected values come from the model
localparam int NROWS = 11;

localparam prog_row_t PROGS [NROWS] = '{
    // lit 1, lit 2, lit 3, swap, drop, bye
    '{128'h01010102_01030503_0D000000_00000000, 8'h00, 32'd3, 32'd1, 5'd2, 1'b0},
    // lit 9, lit 4, over, bye
    '{128'h01090104_040D0000_00000000_00000000, 8'h00, 32'd9, 32'd4, 5'd3, 1'b0},
    // lit 6, dup, lit 5, drop, bye
    '{128'h01060201_05030D00_00000000_00000000, 8'h00, 32'd6, 32'd6, 5'd2, 1'b0},
    // lit 5, lit 9, sub, bye   wraps below zero
    '{128'h01050109_070D0000_00000000_00000000, 8'h00, 32'hFFFF_FFFC, 32'd0, 5'd1, 1'b0},
    // lit 3, neg, bye
    '{128'h01030C0D_00000000_00000000_00000000, 8'h00, 32'hFFFF_FFFD, 32'd0, 5'd1, 1'b0},
    // lit 2, six dups, add, mul, bye   more entries than the queue holds
    '{128'h01020202_02020202_06080D00_00000000, 8'h00, 32'd8, 32'd2, 5'd5, 1'b0},
    // lit 42, bye   restart after a deep stack
    '{128'h012A0D00_00000000_00000000_00000000, 8'h00, 32'd42, 32'd0, 5'd1, 1'b0},
    // first row again at 0x40 with unused bytes 2A, FF and 0E in opcode slots
    '{128'h01012A01_020103FF_05030E0D_00000000, 8'h40, 32'd3, 32'd1, 5'd2, 1'b0},
    // lit, lit, add, lit, sub, bye
    '{128'h01000100_06010007_0D000000_00000000, 8'h00, 32'd0, 32'd0, 5'd0, 1'b1},
    // lit, dup mul three times, bye   x^8 overflows 32 bits
    '{128'h01000208_02080208_0D000000_00000000, 8'h80, 32'd0, 32'd0, 5'd0, 1'b1},
    // lit, lit, and, lit, or, lit, xor, neg, bye
    '{128'h01000100_0901000A_01000B0C_0D000000, 8'h20, 32'd0, 32'd0, 5'd0, 1'b1}
};

//--- test/forth_tb.sv
// testbench for forth_core, runs the program table in forth_programs.svh
// stops at the first wrong value, each run must reach done within 200 cycles
module forth_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [0:15][7:0]              code;
        logic [forth_cfg_pkg::ASZ-1:0] base;
        logic [forth_cfg_pkg::DSZ-1:0] exp_tos;
        logic [forth_cfg_pkg::DSZ-1:0] exp_s0;
        logic [forth_cfg_pkg::SPW-1:0] exp_depth;
        logic                          rnd;   // literals drawn at run time
    } prog_row_t;

    `include "forth_programs.svh"

    logic                          clk;
    logic                          rst;
    logic                          load_we;
    logic [forth_cfg_pkg::ASZ-1:0] load_addr;
    logic [7:0]                    load_data;
    logic                          start;
    logic [forth_cfg_pkg::ASZ-1:0] pfa;
    logic                          bsy;
    logic                          done;
    logic [forth_cfg_pkg::DSZ-1:0] tos;
    logic [forth_cfg_pkg::DSZ-1:0] s0;
    logic [forth_cfg_pkg::SPW-1:0] depth;
    logic [15:0]                   lfsr_state;

    forth_core uut (
        .clk(clk), .rst(rst),
        .load_we(load_we), .load_addr(load_addr), .load_data(load_data),
        .start(start), .pfa(pfa),
        .bsy(bsy), .done(done), .tos(tos), .s0(s0), .depth(depth)
    );

    always #5 clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // taps 16,14,13,11
    endfunction

    task automatic draw_byte(output logic [7:0] b);
        b = '0;
        for (int k = 0; k < 8; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b = {b[6:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    // put a fresh random byte behind every DOLIT
    task automatic fill_literals(inout logic [0:15][7:0] code);
        int         i;
        logic [7:0] lit;
        i = 0;
        while (i < 15) begin
            if (code[i] == forth_op_pkg::OP_DOLIT) begin
                draw_byte(lit);
                code[i+1] = lit;
                i += 2;
            end else begin
                i++;
            end
        end
    endtask

    // second from top combined with top, 32-bit wraparound
    function automatic logic [31:0] binary_result(input logic [7:0] op, input logic [31:0] a,
                                                  input logic [31:0] b);
        case (op)
            forth_op_pkg::OP_ADD: return a + b;
            forth_op_pkg::OP_SUB: return a - b;
            forth_op_pkg::OP_MUL: return a * b;
            forth_op_pkg::OP_AND: return a & b;
            forth_op_pkg::OP_OR:  return a | b;
            default:              return a ^ b;
        endcase
    endfunction

    // reference model, a plain array stack with the top at d-1
    task automatic model_program(input logic [0:15][7:0] code, output logic [31:0] m_tos,
                                 output logic [31:0] m_s0, output logic [4:0] m_depth);
        logic [31:0] stk [20];
        logic [31:0] tmp;
        int          d;
        int          i;
        logic        stop;
        d    = 0;
        i    = 0;
        stop = 1'b0;
        while (!stop && i < 16) begin
            case (code[i])
                forth_op_pkg::OP_DOLIT: begin
                    stk[d] = 32'(code[i+1]);
                    d++;
                    i++;   // skip the literal byte
                end
                forth_op_pkg::OP_DUP: begin
                    stk[d] = stk[d-1];
                    d++;
                end
                forth_op_pkg::OP_OVER: begin
                    stk[d] = stk[d-2];
                    d++;
                end
                forth_op_pkg::OP_DROP: d--;
                forth_op_pkg::OP_SWAP: begin
                    tmp      = stk[d-1];
                    stk[d-1] = stk[d-2];
                    stk[d-2] = tmp;
                end
                forth_op_pkg::OP_ADD, forth_op_pkg::OP_SUB, forth_op_pkg::OP_MUL,
                forth_op_pkg::OP_AND, forth_op_pkg::OP_OR, forth_op_pkg::OP_XOR: begin
                    stk[d-2] = binary_result(code[i], stk[d-2], stk[d-1]);
                    d--;
                end
                forth_op_pkg::OP_NEG: stk[d-1] = -stk[d-1];
                forth_op_pkg::OP_BYE: stop = 1'b1;
                default: ;   // NOP and unused bytes
            endcase
            i++;
        end
        m_tos   = (d >= 1) ? stk[d-1] : '0;
        m_s0    = (d >= 2) ? stk[d-2] : '0;   // empty cells read as zero
        m_depth = 5'(d);
    endtask

    task automatic load_program(input logic [0:15][7:0] code, input logic [7:0] base);
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            load_we   = 1'b1;
            load_addr = base + 8'(i);
            load_data = code[i];
        end
        @(negedge clk);
        load_we = 1'b0;
    endtask

    task automatic run_program(input logic [7:0] base, input int row);
        int n;
        @(negedge clk);
        start = 1'b1;
        pfa   = base;
        @(negedge clk);
        start = 1'b0;
        check_value("bsy", 32'(bsy), 32'd1);
        n = 0;
        while (!done && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (!done) begin
            $display("program %0d did not reach done within 200 cycles", row);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    endtask

    initial begin
        logic [0:15][7:0] code;
        logic [31:0]      e_tos;
        logic [31:0]      e_s0;
        logic [4:0]       e_depth;
        clk        = 1'b0;
        rst        = 1'b1;
        load_we    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        start      = 1'b0;
        pfa        = '0;
        lfsr_state = 16'd24;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("bsy", 32'(bsy), 32'd0);
        check_value("done", 32'(done), 32'd0);
        check_value("depth", 32'(depth), 32'd0);

        for (int r = 0; r < NROWS; r++) begin
            code = PROGS[r].code;
            if (PROGS[r].rnd) begin
                fill_literals(code);
                model_program(code, e_tos, e_s0, e_depth);
            end else begin
                e_tos   = PROGS[r].exp_tos;
                e_s0    = PROGS[r].exp_s0;
                e_depth = PROGS[r].exp_depth;
            end
            load_program(code, PROGS[r].base);
            run_program(PROGS[r].base, r);
            check_value("bsy", 32'(bsy), 32'd0);   // falls together with done
            check_value("tos", tos, e_tos);
            check_value("s0", s0, e_s0);
            check_value("depth", 32'(depth), 32'(e_depth));
            @(negedge clk);
            check_value("done", 32'(done), 32'd0);   // one cycle pulse
            check_value("tos", tos, e_tos);          // held until the next start
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
